// ==== src/synth_pkg.sv ====
// --------------------
// shared widths, micro-op encoding and register map of the synth voice
// imported by every design module
// --------------------
`default_nettype none

package synth_pkg;

	// datapath widths
	localparam int ACC_BITS = 10;
	localparam int OSC_BITS = 20;
	localparam int OUT_BITS = 10;
	localparam int OCT_BITS = 3;
	localparam int SLANT_BITS = 3;
	localparam int SAR_BITS = 3;
	localparam int OSC_SEL_BITS = 5;
	localparam int ACC_NBITS_BITS = 4;

	// frame = update steps, then one 64-cycle channel pass
	localparam int TIMER_BITS = 6;
	localparam int UPDATE_CYCLES = 4;
	localparam int FRAME_CYCLES = UPDATE_CYCLES + 2**TIMER_BITS;

	// oscillator counts down from here
	localparam logic [OSC_BITS-1:0] OSC_RESET_VALUE = '1;

	typedef enum logic [2:0] {
		T1_ZERO, T1_MINUS_ONE, T1_OUT_ACC, T1_ACC, T1_ACC_ROR1, T1_ACC_SHR1, T1_ACC_SAR1
	} term1_sel_t;

	typedef enum logic [2:0] {
		T2_ZERO, T2_ALMOST_ONE, T2_OSC_LOW, T2_OSC_HIGH, T2_ACC, T2_AMPLITUDE, T2_SLANT
	} term2_sel_t;

	typedef struct packed {
		logic p_sign_acc;
		logic use_p0;
		logic inv_p0;
		logic use_p1;
		logic neg_term2;
		logic neg_term2_if_neg;
		logic flip_if_neg;
		logic inv_p_result;
		logic p_result_ov;
		logic carry_in_p1;
		logic zext;
	} alu_flags_t;

	typedef struct packed {
		logic osc_low;
		logic osc_high;
		logic acc;
		logic out_acc;
		logic p0;
		logic p1;
		logic out;
	} we_t;

	typedef struct packed {
		term1_sel_t term1;
		term2_sel_t term2;
		alu_flags_t flags;
		// all ones = unconditional
		logic [OSC_SEL_BITS-1:0] osc_cond_bit;
		// low acc bits left untouched
		logic [ACC_NBITS_BITS-1:0] acc_we_nbits;
		we_t we;
	} micro_op_t;

	typedef struct packed {
		logic [ACC_BITS-1:0] amplitude;
		logic [ACC_BITS-1:0] slant_level;
		logic [OCT_BITS-1:0] oct;
		logic saw;
		logic [SLANT_BITS-1:0] n_slant;
		logic [SAR_BITS-1:0] n_sar;
	} voice_cfg_t;

	// single flags, or-ed together by the sequencer
	localparam alu_flags_t FL_SIGN_ACC = '{p_sign_acc: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_P0 = '{use_p0: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_INV_P0 = '{inv_p0: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_P1 = '{use_p1: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_NEG = '{neg_term2: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_NEG_IF_NEG = '{neg_term2_if_neg: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_FLIP = '{flip_if_neg: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_OV = '{p_result_ov: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_CARRY_P1 = '{carry_in_p1: 1'b1, default: 1'b0};
	localparam alu_flags_t FL_ZEXT = '{zext: 1'b1, default: 1'b0};

	localparam we_t WE_OSC_LOW = '{osc_low: 1'b1, default: 1'b0};
	localparam we_t WE_OSC_HIGH = '{osc_high: 1'b1, default: 1'b0};
	localparam we_t WE_ACC = '{acc: 1'b1, default: 1'b0};
	localparam we_t WE_OUT_ACC = '{out_acc: 1'b1, default: 1'b0};
	localparam we_t WE_P0 = '{p0: 1'b1, default: 1'b0};
	localparam we_t WE_P1 = '{p1: 1'b1, default: 1'b0};
	localparam we_t WE_OUT = '{out: 1'b1, default: 1'b0};

	localparam micro_op_t NOP_OP = '{term1: T1_ZERO, term2: T2_ZERO, flags: '0,
		osc_cond_bit: '1, acc_we_nbits: '0, we: '0};

	// wishbone word addresses
	localparam logic [1:0] REG_AMPLITUDE = 2'd0;
	localparam logic [1:0] REG_SHAPE = 2'd1;
	localparam logic [1:0] REG_SAMPLE = 2'd2;
	localparam logic [1:0] REG_FRAMES = 2'd3;

	// REG_SHAPE field positions
	localparam int SHAPE_OCT_LSB = 0;
	localparam int SHAPE_SAW_BIT = 3;
	localparam int SHAPE_N_SLANT_LSB = 4;
	localparam int SHAPE_N_SAR_LSB = 8;
	localparam int SHAPE_SLANT_LSB = 16;

endpackage

`default_nettype wire

// ==== src/synth_alu.sv ====
// --------------------
// voice ALU: term muxes, adder, predicate and state registers
// one micro-op per cycle from the sequencer
// --------------------
`timescale 1ns/1ns
`default_nettype none

module synth_alu import synth_pkg::*; (
	input logic clk,
	input logic reset,
	input logic alu_en,
	input micro_op_t op,
	input logic signed [ACC_BITS-1:0] amplitude,
	input logic signed [ACC_BITS-1:0] slant_level,
	output logic publish,
	output logic [OUT_BITS-1:0] out_value
);

	logic [OSC_BITS-1:0] osc;
	logic [ACC_BITS-1:0] acc;
	logic [OUT_BITS-1:0] out_acc_q;
	logic p0;
	logic p1;

	logic [OSC_BITS-1:0] osc_shifted;
	logic osc_cond;
	logic cond;
	logic en_eff;
	logic is_neg;
	logic negate;
	logic carry_in;
	logic sext;
	logic p_carry_only;
	logic p_result0;
	logic p_result;
	term2_sel_t term2_sel_eff;
	logic [ACC_BITS-1:0] term1;
	logic [ACC_BITS-1:0] term2_src;
	logic [ACC_BITS-1:0] term2;
	logic [ACC_BITS-1:0] acc_mask;
	logic [ACC_BITS:0] sum;

	// oscillator bit picks whether term2 takes part
	assign osc_shifted = osc >> op.osc_cond_bit;
	assign osc_cond = (op.osc_cond_bit == '1) | osc_shifted[0];

	// gating of the whole micro-op
	assign cond = (op.flags.p_sign_acc ? acc[ACC_BITS-1] : 1'b1) &
		(op.flags.use_p0 ? (p0 ^ op.flags.inv_p0) : 1'b1) &
		(op.flags.use_p1 ? p1 : 1'b1);
	assign en_eff = alu_en & cond;

	always_comb begin
		case (op.term1)
			T1_ZERO: term1 = '0;
			T1_MINUS_ONE: term1 = '1;
			T1_OUT_ACC: term1 = out_acc_q;
			T1_ACC: term1 = acc;
			T1_ACC_ROR1: term1 = {acc[0], acc[ACC_BITS-1:1]};
			T1_ACC_SHR1: term1 = {1'b0, acc[ACC_BITS-1:1]};
			T1_ACC_SAR1: term1 = {acc[ACC_BITS-1], acc[ACC_BITS-1:1]};
			default: term1 = '0;
		endcase
	end

	// false osc condition turns term2 into zero
	assign term2_sel_eff = osc_cond ? op.term2 : T2_ZERO;

	always_comb begin
		case (term2_sel_eff)
			T2_ZERO: term2_src = '0;
			T2_ALMOST_ONE: term2_src = {1'b0, {(ACC_BITS-1){1'b1}}};
			T2_OSC_LOW: term2_src = osc[ACC_BITS-1:0];
			T2_OSC_HIGH: term2_src = osc[OSC_BITS-1:ACC_BITS];
			T2_ACC: term2_src = acc;
			T2_AMPLITUDE: term2_src = amplitude;
			T2_SLANT: term2_src = slant_level;
			default: term2_src = '0;
		endcase
	end

	// ones complement plus carry-in gives the negation
	assign is_neg = acc[ACC_BITS-1];
	assign negate = op.flags.neg_term2 ^ (op.flags.neg_term2_if_neg & is_neg);
	assign term2 = term2_src ^ {ACC_BITS{negate}};
	assign carry_in = op.flags.carry_in_p1 ? p1 : negate;

	// one extra bit for carry or overflow
	assign sext = ~op.flags.zext;
	assign sum = {sext & term1[ACC_BITS-1], term1} + {sext & term2[ACC_BITS-1], term2} +
		(ACC_BITS+1)'(carry_in);

	// zext with ov: plain carry out, else sign xor ov bit
	assign p_carry_only = op.flags.p_result_ov & op.flags.zext;
	assign p_result0 = (p_carry_only ? 1'b0 : sum[ACC_BITS-1]) ^
		(op.flags.p_result_ov & sum[ACC_BITS]);
	assign p_result = p_result0 ^ (op.flags.flip_if_neg & is_neg) ^ op.flags.inv_p_result;

	// bits below acc_we_nbits keep their value
	assign acc_mask = {ACC_BITS{1'b1}} << op.acc_we_nbits;

	always_ff @(posedge clk) begin
		if (reset) begin
			osc <= OSC_RESET_VALUE;
			acc <= '0;
			out_acc_q <= '0;
			p0 <= 1'b0;
			p1 <= 1'b0;
		end else if (en_eff) begin
			if (op.we.osc_low)
				osc[ACC_BITS-1:0] <= sum[ACC_BITS-1:0];
			if (op.we.osc_high)
				osc[OSC_BITS-1:ACC_BITS] <= sum[OSC_BITS-ACC_BITS-1:0];
			if (op.we.acc)
				acc <= (acc & ~acc_mask) | (sum[ACC_BITS-1:0] & acc_mask);
			if (op.we.out_acc)
				out_acc_q <= sum[OUT_BITS-1:0];
			if (op.we.p0)
				p0 <= p_result;
			if (op.we.p1)
				p1 <= p_result;
		end
	end

	assign publish = en_eff & op.we.out;
	assign out_value = out_acc_q;

	// sequencer only names real oscillator bits
	a_cond_bit: assert property (@(posedge clk) disable iff (reset)
		alu_en |-> (op.osc_cond_bit < OSC_SEL_BITS'(OSC_BITS) || op.osc_cond_bit == '1))
		else $error("osc_cond_bit out of range");

	// accumulator starts empty after each publish, no channel counted twice
	a_pub_clear: assert property (@(posedge clk) disable iff (reset)
		publish |=> (out_acc_q == '0))
		else $error("out_acc not cleared by publish");

endmodule

`default_nettype wire

// ==== src/voice_sequencer.sv ====
// --------------------
// frame timer and micro-op decode
// steps 0-3 update the oscillator, steps 4-67 run the channel program
// --------------------
`timescale 1ns/1ns
`default_nettype none

module voice_sequencer import synth_pkg::*; (
	input logic clk,
	input logic reset,
	input voice_cfg_t voice_cfg,
	output logic frame_start,
	output logic alu_en,
	output micro_op_t op
);

	logic [6:0] timer;
	logic first_frame;
	logic [TIMER_BITS-1:0] c;
	logic [OCT_BITS-1:0] n_shr;
	logic [3:0] ror_idx;
	alu_flags_t saw_flags;
	alu_flags_t clamp_flags;

	function automatic micro_op_t make_op(input term1_sel_t t1, input term2_sel_t t2,
		input alu_flags_t fl, input we_t w);
		micro_op_t m;
		m.term1 = t1;
		m.term2 = t2;
		m.flags = fl;
		m.osc_cond_bit = '1;
		m.acc_we_nbits = '0;
		m.we = w;
		return m;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			timer <= '0;
			first_frame <= 1'b1;
			alu_en <= 1'b0;
		end else begin
			alu_en <= 1'b1;
			if (timer == 7'(FRAME_CYCLES - 1)) begin
				timer <= '0;
				first_frame <= 1'b0;
			end else begin
				timer <= timer + 7'd1;
			end
		end
	end

	assign frame_start = (timer == '0);

	// channel step within the 64-cycle pass
	assign c = TIMER_BITS'(timer - 7'(UPDATE_CYCLES));
	assign n_shr = ~voice_cfg.oct;
	// multiply bit index of the ror part
	assign ror_idx = c[4:1] - 4'd5;
	assign saw_flags = voice_cfg.saw ? FL_P1 : '0;
	// last clamp pair always runs, even for saw
	assign clamp_flags = (c[3:1] == 3'd7) ? '0 : saw_flags;

	always_comb begin
		op = NOP_OP;
		if (timer < 7'(UPDATE_CYCLES)) begin
			// no sample exists yet in the first frame
			if (!first_frame) begin
				case (timer[1:0])
					// osc_low -= 1, p1 = no borrow
					2'd0: op = make_op(T1_MINUS_ONE, T2_OSC_LOW, FL_ZEXT | FL_OV,
						WE_OSC_LOW | WE_P1);
					// osc_high += p1 - 1
					2'd1: op = make_op(T1_MINUS_ONE, T2_OSC_HIGH,
						FL_ZEXT | FL_OV | FL_CARRY_P1, WE_OSC_HIGH);
					// publish, restart accumulation
					2'd2: op = make_op(T1_ZERO, T2_ZERO, '0, WE_OUT_ACC | WE_OUT);
					default: op = NOP_OP;
				endcase
			end
		end else if (!c[5]) begin
			if (c[4:3] == 2'd0) begin
				if (c[2:0] != 3'd7) begin
					// acc = shr(acc) + (osc[c] ? amplitude : 0), octave dependent count
					if (c[2:0] < n_shr) begin
						op = make_op((c[2:0] == 3'd0) ? T1_ZERO : T1_ACC_SHR1, T2_AMPLITUDE,
							'0, WE_ACC);
						op.osc_cond_bit = OSC_SEL_BITS'(c[2:0]);
					end
				end else begin
					op = make_op(T1_ACC_SHR1, T2_ZERO, '0, WE_ACC);
				end
			end else if (c[4:1] == 4'hf) begin
				// p1 = phase negative, then fold it
				if (!c[0])
					op = make_op(T1_ACC, T2_ZERO, '0, WE_P1);
				else
					op = make_op(T1_MINUS_ONE, T2_ACC, FL_NEG | FL_SIGN_ACC, WE_ACC);
			end else if (c[4:1] >= 4'd5) begin
				// ror part, add into the upper bits then rotate
				if (!c[0]) begin
					op = make_op(T1_ACC, T2_AMPLITUDE, '0, WE_ACC);
					op.osc_cond_bit = OSC_SEL_BITS'(ror_idx) + OSC_SEL_BITS'(n_shr);
					op.acc_we_nbits = ror_idx;
				end else begin
					op = make_op(T1_ACC_ROR1, T2_ZERO, '0, WE_ACC);
				end
			end
		end else if (!c[4]) begin
			if (c[3:2] == 2'd0) begin
				// triangle: x = 2x - almost one
				case (c[1:0])
					2'd0: op = make_op(T1_ACC, T2_ACC, '0, WE_ACC);
					2'd1: op = make_op(T1_ACC, T2_ALMOST_ONE, FL_NEG, WE_ACC);
					default: op = NOP_OP;
				endcase
			end else if (c[3:1] == 3'd7 || c[3:1] <= voice_cfg.n_slant) begin
				// double, saturate on overflow
				if (!c[0])
					op = make_op(T1_ACC, T2_ACC, FL_FLIP | clamp_flags, WE_ACC | WE_P0);
				else
					op = make_op(T1_ZERO, T2_ALMOST_ONE,
						FL_NEG | FL_FLIP | FL_NEG_IF_NEG | FL_P0 | clamp_flags, WE_ACC);
			end
		end else begin
			case (c[3:0])
				// p0 = inside +-slant_level
				4'd0: op = make_op(T1_ACC, T2_SLANT,
					FL_NEG | FL_FLIP | FL_NEG_IF_NEG | saw_flags, WE_P0);
				// outside: acc = +-slant_level
				4'd1: op = make_op(T1_ZERO, T2_SLANT,
					FL_NEG_IF_NEG | FL_P0 | FL_INV_P0 | saw_flags, WE_ACC);
				4'd8, 4'd9, 4'd10, 4'd11, 4'd12, 4'd13: begin
					if (c[2:0] < voice_cfg.n_sar)
						op = make_op(T1_ACC_SAR1, T2_ZERO, '0, WE_ACC);
				end
				4'd14: op = make_op(T1_OUT_ACC, T2_ACC, '0, WE_OUT_ACC);
				default: op = NOP_OP;
			endcase
		end
	end

	// osc halves are updated one per step so the borrow can chain through p1
	a_osc_halves: assert property (@(posedge clk) disable iff (reset)
		!(op.we.osc_low && op.we.osc_high))
		else $error("both oscillator halves written in one micro-op");

endmodule

`default_nettype wire

// ==== src/wb_voice_regs.sv ====
// --------------------
// wishbone classic slave for voice settings and sample readout
// settings take effect at the next frame start
// --------------------
`timescale 1ns/1ns
`default_nettype none

module wb_voice_regs import synth_pkg::*; (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	input logic frame_start,
	input logic publish,
	input logic [OUT_BITS-1:0] out_value,
	output voice_cfg_t voice_cfg,
	output logic [OUT_BITS-1:0] sample,
	output logic sample_valid
);

	voice_cfg_t pending;
	logic [31:0] frames;
	logic sample_new;
	logic access;
	logic [31:0] rd_data;

	// one access per stb with ack in the following cycle
	assign access = wb_cyc & wb_stb & ~wb_ack;

	always_comb begin
		rd_data = '0;
		case (wb_adr)
			REG_AMPLITUDE: rd_data[ACC_BITS-1:0] = pending.amplitude;
			REG_SHAPE: begin
				rd_data[SHAPE_OCT_LSB +: OCT_BITS] = pending.oct;
				rd_data[SHAPE_SAW_BIT] = pending.saw;
				rd_data[SHAPE_N_SLANT_LSB +: SLANT_BITS] = pending.n_slant;
				rd_data[SHAPE_N_SAR_LSB +: SAR_BITS] = pending.n_sar;
				rd_data[SHAPE_SLANT_LSB +: ACC_BITS] = pending.slant_level;
			end
			REG_SAMPLE: rd_data[OUT_BITS-1:0] = sample;
			REG_FRAMES: rd_data = frames;
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			pending <= '0;
			voice_cfg <= '0;
			sample <= '0;
			sample_new <= 1'b0;
			sample_valid <= 1'b0;
			frames <= '0;
		end else begin
			wb_ack <= access;
			// sample and frame registers ignore writes
			if (access && wb_we) begin
				case (wb_adr)
					REG_AMPLITUDE: pending.amplitude <= wb_dat_w[ACC_BITS-1:0];
					REG_SHAPE: begin
						pending.oct <= wb_dat_w[SHAPE_OCT_LSB +: OCT_BITS];
						pending.saw <= wb_dat_w[SHAPE_SAW_BIT];
						pending.n_slant <= wb_dat_w[SHAPE_N_SLANT_LSB +: SLANT_BITS];
						pending.n_sar <= wb_dat_w[SHAPE_N_SAR_LSB +: SAR_BITS];
						pending.slant_level <= wb_dat_w[SHAPE_SLANT_LSB +: ACC_BITS];
					end
					default: ;
				endcase
			end
			if (frame_start)
				voice_cfg <= pending;
			// valid follows one cycle behind the latched sample
			sample_new <= publish;
			sample_valid <= sample_new;
			if (publish) begin
				sample <= out_value;
				frames <= frames + 32'd1;
			end
		end
	end

	// read data captured with the access and presented with ack
	always_ff @(posedge clk) begin
		if (access)
			wb_dat_r <= rd_data;
	end

	a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wishbone ack held for two cycles");

endmodule

`default_nettype wire

// ==== src/synth_voice_top.sv ====
// --------------------
// synth voice top: bus registers, sequencer and ALU
// --------------------
`timescale 1ns/1ns
`default_nettype none

module synth_voice_top import synth_pkg::*; (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output logic [OUT_BITS-1:0] sample,
	output logic sample_valid
);

	voice_cfg_t voice_cfg;
	micro_op_t op;
	logic frame_start;
	logic alu_en;
	logic publish;
	logic [OUT_BITS-1:0] out_value;

	wb_voice_regs u_regs (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.frame_start(frame_start), .publish(publish), .out_value(out_value),
		.voice_cfg(voice_cfg), .sample(sample), .sample_valid(sample_valid)
	);

	voice_sequencer u_seq (
		.clk(clk), .reset(reset), .voice_cfg(voice_cfg),
		.frame_start(frame_start), .alu_en(alu_en), .op(op)
	);

	// settings feed the ALU as signed terms
	synth_alu u_alu (
		.clk(clk), .reset(reset), .alu_en(alu_en), .op(op),
		.amplitude(voice_cfg.amplitude), .slant_level(voice_cfg.slant_level),
		.publish(publish), .out_value(out_value)
	);

endmodule

`default_nettype wire

// ==== sim/tb_synth_voice.sv ====
// --------------------
// testbench for the synth voice with bus accesses, random settings
// and a frame-level model of the expected samples
// --------------------
`timescale 1ns/1ns
`default_nettype none

module tb_synth_voice import synth_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RUN_FRAMES = 40;
	localparam int BUS_ACCESSES = 40;
	localparam int WATCHDOG_NS = (RUN_FRAMES + 4) * FRAME_CYCLES * CLK_PERIOD +
		BUS_ACCESSES * 3 * CLK_PERIOD;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic [OUT_BITS-1:0] sample;
	logic sample_valid;

	// model copy of the voice registers
	logic [OSC_BITS-1:0] m_osc;
	logic [ACC_BITS-1:0] m_acc;
	logic [OUT_BITS-1:0] m_out_acc;
	logic m_p0;
	logic m_p1;

	// settings as the DUT holds them in its pending copy
	voice_cfg_t cfg_shadow;
	logic [OUT_BITS-1:0] expected_q[$];
	logic [31:0] lfsr_state;
	int edge_count = 0;
	int error_count = 0;
	int samples_seen = 0;
	int ack_count = 0;
	int access_count = 0;

	synth_voice_top u_synth_voice_top (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.sample(sample), .sample_valid(sample_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// galois lfsr with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r[i] = lfsr_state[0];
		end
		return r;
	endfunction

	// first publish on edge 5 + 68, then one per frame
	function automatic int publishes_by_edge(input int e);
		if (e < FRAME_CYCLES + 5)
			return 0;
		return (e - FRAME_CYCLES - 5) / FRAME_CYCLES + 1;
	endfunction

	function automatic logic [31:0] make_shape(input logic [2:0] oct, input logic saw,
		input logic [2:0] n_slant, input logic [2:0] n_sar, input logic [9:0] slant);
		logic [31:0] w;
		w = '0;
		w[SHAPE_OCT_LSB +: OCT_BITS] = oct;
		w[SHAPE_SAW_BIT] = saw;
		w[SHAPE_N_SLANT_LSB +: SLANT_BITS] = n_slant;
		w[SHAPE_N_SAR_LSB +: SAR_BITS] = n_sar;
		w[SHAPE_SLANT_LSB +: ACC_BITS] = slant;
		return w;
	endfunction

	// one channel pass followed by the publish and oscillator step of the next frame
	function automatic logic [OUT_BITS-1:0] model_voice_sample(input voice_cfg_t cfg);
		logic [ACC_BITS-1:0] a;
		logic [ACC_BITS-1:0] s;
		logic [ACC_BITS-1:0] acc;
		logic [ACC_BITS-1:0] sum;
		logic [ACC_BITS-1:0] lowm;
		logic [2:0] n_shr;
		logic old_neg;
		logic [OUT_BITS-1:0] result;
		a = cfg.amplitude;
		s = cfg.slant_level;
		n_shr = 3'd7 - cfg.oct;
		acc = m_acc;
		// shift-and-add over the low phase bits with fewer steps at high octave
		for (int c = 0; c < 7; c++) begin
			if (3'(c) < n_shr)
				acc = ((c == 0) ? 10'd0 : (acc >> 1)) + (m_osc[c] ? a : 10'd0);
		end
		acc = acc >> 1;
		// rotate part keeps the bits below idx
		for (int idx = 0; idx < 10; idx++) begin
			lowm = (10'd1 << idx) - 10'd1;
			sum = acc + (m_osc[idx + int'(n_shr)] ? a : 10'd0);
			acc = (acc & lowm) | (sum & ~lowm);
			acc = {acc[0], acc[9:1]};
		end
		// fold into triangle
		m_p1 = acc[9];
		if (acc[9])
			acc = ~acc;
		acc = acc + acc;
		acc = acc - 10'd511;
		// clamp pairs double with saturation
		for (int k = 2; k < 8; k++) begin
			if ((k == 7 || 3'(k) <= cfg.n_slant) && (k == 7 || !cfg.saw || m_p1)) begin
				old_neg = acc[9];
				acc = acc + acc;
				m_p0 = acc[9] ^ old_neg;
				if (m_p0)
					acc = acc[9] ? 10'd511 : 10'h201;
			end
		end
		// limit to the slant window
		if (!cfg.saw || m_p1) begin
			old_neg = acc[9];
			if (!old_neg) begin
				sum = acc - s;
				m_p0 = sum[9];
			end else begin
				sum = acc + s;
				m_p0 = ~sum[9];
			end
			if (!m_p0)
				acc = old_neg ? (10'd0 - s) : s;
		end
		// attenuation
		for (int k = 0; k < 6; k++) begin
			if (3'(k) < cfg.n_sar)
				acc = {acc[9], acc[9:1]};
		end
		m_acc = acc;
		m_out_acc = m_out_acc + acc;
		result = m_out_acc;
		m_out_acc = '0;
		m_osc = m_osc - 20'd1;
		return result;
	endfunction

	task automatic bus_write(input logic [1:0] adr, input logic [31:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_dat_w <= data;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		// pending copy changed on the edge that raised ack
		case (adr)
			REG_AMPLITUDE: cfg_shadow.amplitude = data[ACC_BITS-1:0];
			REG_SHAPE: begin
				cfg_shadow.oct = data[SHAPE_OCT_LSB +: OCT_BITS];
				cfg_shadow.saw = data[SHAPE_SAW_BIT];
				cfg_shadow.n_slant = data[SHAPE_N_SLANT_LSB +: SLANT_BITS];
				cfg_shadow.n_sar = data[SHAPE_N_SAR_LSB +: SAR_BITS];
				cfg_shadow.slant_level = data[SHAPE_SLANT_LSB +: ACC_BITS];
			end
			default: ;
		endcase
		access_count++;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] adr, output logic [31:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		data = wb_dat_r;
		access_count++;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic write_random_settings();
		logic [31:0] amp;
		logic [31:0] shape;
		amp = rand_bits(ACC_BITS);
		shape = make_shape(rand_bits(3), rand_bits(1), rand_bits(3), rand_bits(3),
			rand_bits(ACC_BITS));
		bus_write(REG_AMPLITUDE, amp);
		bus_write(REG_SHAPE, shape);
	endtask

	task automatic wait_sample();
		@(negedge clk);
		while (!sample_valid)
			@(negedge clk);
	endtask

	// frame n takes its settings on edge 3 + 68n after reset starts
	always @(posedge clk) begin
		edge_count = edge_count + 1;
		if (edge_count >= 3 && (edge_count - 3) % FRAME_CYCLES == 0)
			expected_q.push_back(model_voice_sample(cfg_shadow));
	end

	always @(negedge clk) begin
		if (wb_ack)
			ack_count++;
	end

	// compare each published sample with the model
	always @(negedge clk) begin
		if (!reset && sample_valid) begin
			if (edge_count < FRAME_CYCLES + 6 || edge_count % FRAME_CYCLES != 6) begin
				error_count++;
				$display("sample_valid came outside its slot in the frame at %0t", $time);
			end
			if (expected_q.size() == 0) begin
				error_count++;
				$display("a sample arrived with no expected value at %0t", $time);
			end else begin
				check_value("sample", 32'(sample), 32'(expected_q.pop_front()));
			end
			samples_seen++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] amp;
		logic [31:0] shape;
		int frames_exp;
		clk = 1'b0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		lfsr_state = 32'h953d;
		cfg_shadow = '0;
		m_osc = OSC_RESET_VALUE;
		m_acc = '0;
		m_out_acc = '0;
		m_p0 = 1'b0;
		m_p1 = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// read-only registers start empty
		bus_read(REG_SAMPLE, rd);
		check_value("sample after reset", rd, 32'd0);
		bus_read(REG_FRAMES, rd);
		check_value("frames after reset", rd, 32'd0);

		// settings read back at once
		amp = rand_bits(ACC_BITS);
		bus_write(REG_AMPLITUDE, amp);
		bus_read(REG_AMPLITUDE, rd);
		check_value("amplitude readback", rd, amp);
		shape = make_shape(rand_bits(3), rand_bits(1), rand_bits(3), rand_bits(3),
			rand_bits(ACC_BITS));
		bus_write(REG_SHAPE, shape);
		bus_read(REG_SHAPE, rd);
		check_value("shape readback", rd, shape);
		bus_write(REG_SAMPLE, 32'hffff_ffff);
		bus_read(REG_SAMPLE, rd);
		check_value("sample after write", rd, 32'd0);
		bus_write(REG_FRAMES, 32'h1234_5678);
		bus_read(REG_FRAMES, rd);
		check_value("frames after write", rd, 32'd0);

		// silent voice with one frame count per sample
		bus_write(REG_AMPLITUDE, 32'd0);
		bus_write(REG_SHAPE, 32'd0);
		repeat (2) wait_sample();
		for (int i = 0; i < 4; i++) begin
			wait_sample();
			check_value("silent sample", 32'(sample), 32'd0);
			frames_exp = publishes_by_edge(edge_count);
			bus_read(REG_FRAMES, rd);
			check_value("frame count", rd, frames_exp);
		end

		// random settings held for several frames
		for (int r = 0; r < 4; r++) begin
			write_random_settings();
			repeat (5) wait_sample();
		end

		// changes in the middle of a frame
		for (int r = 0; r < 8; r++) begin
			wait_sample();
			write_random_settings();
		end
		repeat (3) wait_sample();

		check_value("ack count", ack_count, access_count);
		$display("%0d errors, %0d samples, %0d bus accesses", error_count, samples_seen,
			access_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
src/synth_pkg.sv
src/synth_alu.sv
src/voice_sequencer.sv
src/wb_voice_regs.sv
src/synth_voice_top.sv
sim/tb_synth_voice.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --timing --assert
TOP ?= tb_synth_voice
FILELIST ?= compile.f
LOG ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail, the pipe hides the simulator status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
